/* Bender.yml */
package:
  name: rv32_exe

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/exe_pkg.sv
      - rtl/alu.sv
      - rtl/bu.sv
      - rtl/lsu.sv
      - rtl/trap_ctrl.sv
      - rtl/flush_timer.sv
      - rtl/exe.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/exe_checker.sv
      - bench/exe_tb.sv

/* bench/exe_checker.sv */
`default_nettype none

module exe_checker import exe_pkg::*; (
  input logic  clk,
  input logic  reset_n,
  input logic  trap_valid_i,
  input logic  wbk_valid_i,
  input logic  redirect_valid_i,
  input logic  mem_valid_i,
  input logic  kill_i,
  input mode_e core_mode_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far
  int n_fail = 0;

  // A trapping instruction never writes rd
  trap_excludes_wbk: assert property (@(posedge clk) disable iff (!reset_n)
    !(trap_valid_i && wbk_valid_i))
    else begin
      $error("trap_o and wbk_o valid in the same cycle");
      n_fail++;
    end

  // Shadow of two killed instructions after every redirect
  redirect_shadow: assert property (@(posedge clk) disable iff (!reset_n)
    redirect_valid_i |=> (!redirect_valid_i && !wbk_valid_i) [*2])
    else begin
      $error("redirect or write-back inside the kill window");
      n_fail++;
    end

  no_mem_in_kill: assert property (@(posedge clk) disable iff (!reset_n)
    !(mem_valid_i && kill_i))
    else begin
      $error("memory request issued while kill is high");
      n_fail++;
    end

  mode_after_trap: assert property (@(posedge clk) disable iff (!reset_n)
    trap_valid_i |=> core_mode_i == MODE_M)
    else begin
      $error("core mode is not M after a trap");
      n_fail++;
    end

endmodule

bind exe exe_checker u_exe_checker (
  .clk              (clk),
  .reset_n          (reset_n),
  .trap_valid_i     (trap_o.valid),
  .wbk_valid_i      (wbk_o.valid),
  .redirect_valid_i (redirect_o.valid),
  .mem_valid_i      (mem_req_o.valid),
  .kill_i           (kill),
  .core_mode_i      (core_mode_o)
);

`default_nettype wire

/* bench/exe_tb.sv */
`default_nettype none
`include "exe_defs.svh"

module exe_tb import exe_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int T_ALU  = 0;
  localparam int T_BR   = 1;
  localparam int T_LSU  = 2;
  localparam int T_EXC  = 3;
  localparam int T_MODE = 4;
  localparam int T_CSR  = 5;
  localparam int T_MIX  = 6;

  logic                 clk;
  logic                 reset_n;
  dec_exe_t             dec;
  logic [`EXE_XLEN-1:0] load_data;
  logic [`EXE_XLEN-1:0] mtvec;
  logic [`EXE_XLEN-1:0] mepc;
  mem_req_t             mem_req;
  logic [`EXE_XLEN-1:0] fwd_rd;
  logic [`EXE_XLEN-1:0] fwd_csr;
  wbk_t                 wbk;
  csr_wbk_t             csr_wbk;
  redirect_t            redirect;
  trap_t                trap;
  mode_e                core_mode;

  // Data memory of 16 words
  logic [31:0] mem [0:15];

  // Reference model state and expected values
  int          kill_cnt;
  mode_e       model_mode;
  wbk_t        exp_wbk;
  csr_wbk_t    exp_csr;
  redirect_t   exp_redir;
  trap_t       exp_trap;
  mem_req_t    exp_mem;
  logic [31:0] exp_fwd_rd;
  logic [31:0] exp_fwd_csr;
  int          n_checks;
  int          n_errs;
  bit          timed_out;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  exe UUT (
    .clk            (clk),
    .reset_n        (reset_n),
    .dec_i          (dec),
    .load_data_i    (load_data),
    .mtvec_i        (mtvec),
    .mepc_i         (mepc),
    .mem_req_o      (mem_req),
    .fwd_rd_data_o  (fwd_rd),
    .fwd_csr_data_o (fwd_csr),
    .wbk_o          (wbk),
    .csr_wbk_o      (csr_wbk),
    .redirect_o     (redirect),
    .trap_o         (trap),
    .core_mode_o    (core_mode)
  );

  // ------------------------------------------------------------
  // Memory with combinational read and byte-lane writes
  // ------------------------------------------------------------
  assign load_data = mem[mem_req.adr[5:2]];

  always @(posedge clk) begin
    if (reset_n && mem_req.valid && mem_req.store) begin
      case (mem_req.size)
        SIZE_BYTE: mem[mem_req.adr[5:2]][8*mem_req.adr[1:0] +: 8] <= mem_req.wdata[7:0];
        SIZE_HALF: mem[mem_req.adr[5:2]][16*mem_req.adr[1] +: 16] <= mem_req.wdata[15:0];
        default:   mem[mem_req.adr[5:2]] <= mem_req.wdata;
      endcase
    end
  end

  initial begin
    reset_n = 1'b0;
    dec     = '0;
    mtvec   = 32'h0000_0100;
    mepc    = 32'h0000_4000;
    for (int i = 0; i < 16; i++) begin
      mem[i] = (i + 1) * 32'h9e37_79b9;
    end
    repeat (5) @(posedge clk);
    #2;
    reset_n = 1'b1;
  end

  // ------------------------------------------------------------
  // Reference functions
  // ------------------------------------------------------------
  function automatic logic [31:0] ref_alu(input op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
      OP_XOR:  return a ^ b;
      OP_OR:   return a | b;
      OP_AND:  return a & b;
      OP_SLL:  return a << sh;
      OP_SRL:  return a >> sh;
      OP_SRA:  return 32'($signed(a) >>> sh);
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] word, input logic [1:0] off,
                                           input size_e size, input logic uns);
    logic [31:0] b_sh;
    logic [31:0] h_sh;
    b_sh = word >> (8 * off);
    h_sh = word >> (16 * off[1]);
    case (size)
      SIZE_BYTE: return uns ? {24'd0, b_sh[7:0]} : {{24{b_sh[7]}}, b_sh[7:0]};
      SIZE_HALF: return uns ? {16'd0, h_sh[15:0]} : {{16{h_sh[15]}}, h_sh[15:0]};
      default:   return word;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errs++;
      $display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Random instruction biased by test kind
  task automatic gen_instr(input int kind, output dec_exe_t d);
    int          unit_sel;
    int          exc_rate;
    int          ecall_rate;
    int          xret_rate;
    logic [31:0] r;
    d         = '0;
    r         = $urandom;
    d.valid   = $urandom_range(0, 9) != 0;
    d.pc      = $urandom & 32'h000f_fffc;
    d.rs1     = $urandom;
    d.rs2     = ($urandom_range(0, 3) == 0) ? d.rs1 : $urandom;
    d.imm     = {{20{r[11]}}, r[11:0]};
    d.use_imm = $urandom_range(0, 1);
    d.unsign  = $urandom_range(0, 1);
    d.size    = size_e'($urandom_range(0, 2));
    d.rd_v    = $urandom_range(0, 3) != 0;
    d.rd_adr  = 5'($urandom);
    d.csr_adr = 12'($urandom);
    d.csrrw   = $urandom_range(0, 1);
    case (kind)
      T_ALU:         unit_sel = $urandom_range(0, 1);
      T_BR:          unit_sel = 2;
      T_LSU:         unit_sel = 3;
      T_CSR, T_MODE: unit_sel = 4;
      default:       unit_sel = $urandom_range(0, 4);
    endcase
    d.unit = unit_e'(5'b00001 << unit_sel);
    case (d.unit)
      UNIT_SFT: d.op = op_e'(4'($urandom_range(7, 9)));
      UNIT_BU:  d.op = op_e'(4'($urandom_range(10, 15)));
      UNIT_LSU: d.op = ($urandom_range(0, 1) == 1) ? OP_ST : OP_LD;
      default:  d.op = op_e'(4'($urandom_range(0, 6)));
    endcase
    // Mostly aligned targets and addresses
    if ((d.unit inside {UNIT_BU, UNIT_LSU}) && $urandom_range(0, 3) != 0) begin
      d.imm[1:0] = 2'b00;
      d.rs1[1:0] = 2'b00;
    end
    d.csr_wbk  = (kind == T_CSR) || (d.unit == UNIT_NONE && $urandom_range(0, 1) == 1);
    exc_rate   = (kind == T_EXC) ? 30 : 3;
    ecall_rate = (kind == T_EXC || kind == T_MODE) ? 15 : 3;
    xret_rate  = (kind == T_MODE) ? 30 : 3;
    d.illegal  = $urandom_range(0, 99) < exc_rate;
    d.ebreak   = $urandom_range(0, 99) < exc_rate;
    d.ecall    = $urandom_range(0, 99) < ecall_rate;
    if ($urandom_range(0, 99) < xret_rate) begin
      if ($urandom_range(0, 1) == 1) begin
        d.mret = 1'b1;
      end else begin
        d.sret = 1'b1;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Reference model for one presented instruction
  // ------------------------------------------------------------
  task automatic predict(input dec_exe_t d);
    logic        act;
    logic        is_bu;
    logic        is_lsu;
    logic        is_store;
    logic        tk;
    logic        lt;
    logic        mis;
    logic        exc;
    logic        trap_v;
    logic        xret_v;
    logic        redir_v;
    logic [31:0] b;
    logic [31:0] alu_r;
    logic [31:0] tgt;
    logic [31:0] eff;
    logic [31:0] rd;
    logic [31:0] cause;
    logic [31:0] tval;
    act      = d.valid && (kill_cnt == 0);
    is_bu    = d.unit == UNIT_BU;
    is_lsu   = d.unit == UNIT_LSU;
    is_store = d.op == OP_ST;
    b        = d.use_imm ? d.imm : d.rs2;
    alu_r    = ref_alu(d.op, d.rs1, b);
    lt       = d.unsign ? (d.rs1 < d.rs2) : ($signed(d.rs1) < $signed(d.rs2));
    case (d.op)
      OP_BEQ:           tk = d.rs1 == d.rs2;
      OP_BNE:           tk = d.rs1 != d.rs2;
      OP_BLT:           tk = lt;
      OP_BGE:           tk = !lt;
      OP_JAL, OP_JALR:  tk = 1'b1;
      default:          tk = 1'b0;
    endcase
    tgt = (d.op == OP_JALR) ? ((d.rs1 + d.imm) & 32'hffff_fffe) : (d.pc + d.imm);
    eff = d.rs1 + d.imm;
    mis = (d.size == SIZE_HALF && eff[0]) || (d.size == SIZE_WORD && eff[1:0] != 2'b00);
    exc   = 1'b1;
    cause = 32'd0;
    tval  = 32'd0;
    if (is_bu && tk && tgt[1:0] != 2'b00) begin
      tval = tgt;
    end else if (d.illegal) begin
      cause = 32'd2;
    end else if (d.ebreak) begin
      cause = 32'd3;
    end else if (is_lsu && mis) begin
      cause = is_store ? 32'd6 : 32'd4;
      tval  = eff;
    end else if (d.ecall) begin
      cause = 32'd11;
    end else begin
      exc = 1'b0;
    end
    trap_v  = act && exc;
    xret_v  = act && !exc && (d.mret || d.sret);
    redir_v = (act && is_bu && tk) || trap_v || xret_v;
    if (d.csr_wbk) begin
      rd = d.rs2;
    end else begin
      case (d.unit)
        UNIT_ALU, UNIT_SFT: rd = alu_r;
        UNIT_BU:            rd = d.pc + 32'd4;
        UNIT_LSU:           rd = ref_load(mem[eff[5:2]], eff[1:0], d.size, d.unsign);
        default:            rd = 32'd0;
      endcase
    end
    exp_fwd_rd  = rd;
    exp_fwd_csr = d.csrrw ? d.rs1 : alu_r;
    exp_mem   = '{valid: act && is_lsu && !trap_v, store: is_store, adr: eff,
                  wdata: d.rs2, size: d.size};
    exp_wbk   = '{valid: act && d.rd_v && !trap_v, adr: d.rd_adr, data: rd};
    exp_csr   = '{valid: act && d.csr_wbk && !trap_v, adr: d.csr_adr, data: exp_fwd_csr};
    exp_redir = '{valid: redir_v, pc: trap_v ? mtvec : (xret_v ? mepc : tgt)};
    exp_trap  = '{valid: trap_v, cause: cause, tval: tval, epc: d.pc};
    if (trap_v) begin
      model_mode = MODE_M;
    end else if (xret_v && d.mret) begin
      model_mode = MODE_U;
    end else if (xret_v) begin
      model_mode = MODE_S;
    end
    if (redir_v) begin
      kill_cnt = `EXE_KILL_CYCLES;
    end else if (kill_cnt > 0) begin
      kill_cnt--;
    end
  endtask

  task automatic check_regs();
    check_value("wbk_o.valid", wbk.valid, exp_wbk.valid);
    if (exp_wbk.valid) begin
      check_value("wbk_o.adr", wbk.adr, exp_wbk.adr);
      check_value("wbk_o.data", wbk.data, exp_wbk.data);
    end
    check_value("csr_wbk_o.valid", csr_wbk.valid, exp_csr.valid);
    if (exp_csr.valid) begin
      check_value("csr_wbk_o.adr", csr_wbk.adr, exp_csr.adr);
      check_value("csr_wbk_o.data", csr_wbk.data, exp_csr.data);
    end
    check_value("redirect_o.valid", redirect.valid, exp_redir.valid);
    if (exp_redir.valid) begin
      check_value("redirect_o.pc", redirect.pc, exp_redir.pc);
    end
    check_value("trap_o.valid", trap.valid, exp_trap.valid);
    if (exp_trap.valid) begin
      check_value("trap_o.cause", trap.cause, exp_trap.cause);
      check_value("trap_o.tval", trap.tval, exp_trap.tval);
      check_value("trap_o.epc", trap.epc, exp_trap.epc);
    end
    check_value("core_mode_o", core_mode, model_mode);
  endtask

  task automatic check_comb(input dec_exe_t d);
    check_value("mem_req_o.valid", mem_req.valid, exp_mem.valid);
    if (exp_mem.valid) begin
      check_value("mem_req_o.store", mem_req.store, exp_mem.store);
      check_value("mem_req_o.adr", mem_req.adr, exp_mem.adr);
      check_value("mem_req_o.wdata", mem_req.wdata, exp_mem.wdata);
      check_value("mem_req_o.size", mem_req.size, exp_mem.size);
    end
    if (d.valid) begin
      check_value("fwd_rd_data_o", fwd_rd, exp_fwd_rd);
      if (d.csr_wbk) begin
        check_value("fwd_csr_data_o", fwd_csr, exp_fwd_csr);
      end
    end
  endtask

  // Check the previous results then drive and check one instruction
  task automatic issue_cycle(input dec_exe_t d);
    @(posedge clk);
    #1;
    check_regs();
    #1;
    dec = d;
    predict(d);
    #5;
    check_comb(d);
  endtask

  task automatic run_test(input string name, input int kind, input int count);
    dec_exe_t d;
    int       errs_before;
    int       n;
    errs_before = n_errs;
    mtvec = $urandom & 32'hffff_fffc;
    mepc  = $urandom & 32'hffff_fffc;
    repeat (count) begin
      gen_instr(kind, d);
      issue_cycle(d);
    end
    // Idle slots until the kill window closes
    n = 0;
    while (kill_cnt != 0 && n < 8) begin
      issue_cycle('0);
      n++;
    end
    if (kill_cnt != 0) begin
      timed_out = 1'b1;
      $display("%s: kill window did not close within 8 cycles", name);
    end
    issue_cycle('0);
    $display("test %-10s %0d errors", name, n_errs - errs_before);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int n;
    void'($urandom(32'heecf));
    n_checks   = 0;
    n_errs     = 0;
    timed_out  = 1'b0;
    kill_cnt   = 0;
    model_mode = MODE_M;
    exp_wbk    = '0;
    exp_csr    = '0;
    exp_redir  = '0;
    exp_trap   = '0;
    exp_mem    = '0;
    n = 0;
    while (reset_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      #1;
      check_regs();
      check_value("mem_req_o.valid", mem_req.valid, 1'b0);
      n++;
    end
    if (reset_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("reset_n was not released within 20 cycles");
    end else begin
      $display("test %-10s %0d errors", "reset", n_errs);
      run_test("alu", T_ALU, 400);
      run_test("branch", T_BR, 400);
      run_test("lsu", T_LSU, 400);
      run_test("exception", T_EXC, 400);
      run_test("mode", T_MODE, 400);
      run_test("csr", T_CSR, 300);
      run_test("mixed", T_MIX, 600);
    end
    $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errs,
             UUT.u_exe_checker.n_fail);
    if (!timed_out && n_errs == 0 && UUT.u_exe_checker.n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+rtl
rtl/exe_pkg.sv
rtl/alu.sv
rtl/bu.sv
rtl/lsu.sv
rtl/trap_ctrl.sv
rtl/flush_timer.sv
rtl/exe.sv
bench/exe_checker.sv
bench/exe_tb.sv

/* rtl/alu.sv */
`default_nettype none
`include "exe_defs.svh"

module alu import exe_pkg::*; (
  input  op_e                  op_i,
  input  logic [`EXE_XLEN-1:0] a_i,
  input  logic [`EXE_XLEN-1:0] b_i,
  output logic [`EXE_XLEN-1:0] res_o
);

  localparam int SHW = $clog2(`EXE_XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;

  // Shift amount from the low bits of the second operand
  assign shamt = b_i[SHW-1:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      OP_ADD:  res_o = a_i + b_i;
      OP_SUB:  res_o = a_i - b_i;
      OP_SLT:  res_o = `EXE_XLEN'(lt_s);
      OP_SLTU: res_o = `EXE_XLEN'(lt_u);
      OP_XOR:  res_o = a_i ^ b_i;
      OP_OR:   res_o = a_i | b_i;
      OP_AND:  res_o = a_i & b_i;
      // Shifter
      OP_SLL:  res_o = a_i << shamt;
      OP_SRL:  res_o = a_i >> shamt;
      OP_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
      default: res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/bu.sv */
`default_nettype none
`include "exe_defs.svh"

module bu import exe_pkg::*; (
  input  op_e                  op_i,
  input  logic                 unsign_i,
  input  logic [`EXE_XLEN-1:0] rs1_i,
  input  logic [`EXE_XLEN-1:0] rs2_i,
  input  logic [`EXE_XLEN-1:0] imm_i,
  input  logic [`EXE_XLEN-1:0] pc_i,
  output logic                 taken_o,
  output logic [`EXE_XLEN-1:0] target_o,
  output logic [`EXE_XLEN-1:0] link_o,
  output logic                 target_misaligned_o
);

  logic eq;
  logic lt;

  assign eq = rs1_i == rs2_i;
  // Signed compare unless unsigned branch
  assign lt = unsign_i ? (rs1_i < rs2_i) : ($signed(rs1_i) < $signed(rs2_i));

  always_comb begin
    case (op_i)
      OP_BEQ:  taken_o = eq;
      OP_BNE:  taken_o = ~eq;
      OP_BLT:  taken_o = lt;
      OP_BGE:  taken_o = ~lt;
      OP_JAL,
      OP_JALR: taken_o = 1'b1;
      default: taken_o = 1'b0;
    endcase
  end

  // JALR drops bit 0 of the sum
  assign target_o = (op_i == OP_JALR) ? ((rs1_i + imm_i) & ~`EXE_XLEN'(1)) : (pc_i + imm_i);
  assign link_o   = pc_i + `EXE_XLEN'(4);

  assign target_misaligned_o = taken_o & (|target_o[1:0]);

endmodule

`default_nettype wire

/* rtl/exe.sv */
`default_nettype none
`include "exe_defs.svh"

module exe import exe_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_n,
  input  dec_exe_t             dec_i,
  input  logic [`EXE_XLEN-1:0] load_data_i,
  input  logic [`EXE_XLEN-1:0] mtvec_i,
  input  logic [`EXE_XLEN-1:0] mepc_i,
  output mem_req_t             mem_req_o,
  output logic [`EXE_XLEN-1:0] fwd_rd_data_o,
  output logic [`EXE_XLEN-1:0] fwd_csr_data_o,
  output wbk_t                 wbk_o,
  output csr_wbk_t             csr_wbk_o,
  output redirect_t            redirect_o,
  output trap_t                trap_o,
  output mode_e                core_mode_o
);

  logic                 sel_bu;
  logic                 sel_lsu;
  logic                 active;
  logic                 kill;
  logic [`EXE_XLEN-1:0] alu_b;
  logic [`EXE_XLEN-1:0] alu_res;
  logic                 bu_taken;
  logic                 taken;
  logic [`EXE_XLEN-1:0] bu_target;
  logic [`EXE_XLEN-1:0] bu_link;
  logic                 bu_misaligned;
  mem_req_t             lsu_req;
  logic [`EXE_XLEN-1:0] lsu_res;
  logic                 lsu_misaligned;
  logic                 trap_now;
  logic                 xret_now;
  logic [`EXE_XLEN-1:0] trap_redirect_pc;
  logic                 redirect_now;
  logic [`EXE_XLEN-1:0] rd_data;
  logic [`EXE_XLEN-1:0] csr_data;
  wbk_t                 wbk_q;
  csr_wbk_t             csr_wbk_q;
  redirect_t            redirect_q;

  assign sel_bu  = dec_i.unit == UNIT_BU;
  assign sel_lsu = dec_i.unit == UNIT_LSU;
  assign active  = dec_i.valid & ~kill;
  assign alu_b   = dec_i.use_imm ? dec_i.imm : dec_i.rs2;

  // ------------------------------------------------------------
  // Units
  // ------------------------------------------------------------
  alu u_alu (
    .op_i  (dec_i.op),
    .a_i   (dec_i.rs1),
    .b_i   (alu_b),
    .res_o (alu_res)
  );

  bu u_bu (
    .op_i                (dec_i.op),
    .unsign_i            (dec_i.unsign),
    .rs1_i               (dec_i.rs1),
    .rs2_i               (dec_i.rs2),
    .imm_i               (dec_i.imm),
    .pc_i                (dec_i.pc),
    .taken_o             (bu_taken),
    .target_o            (bu_target),
    .link_o              (bu_link),
    .target_misaligned_o (bu_misaligned)
  );

  lsu u_lsu (
    .en_i         (sel_lsu),
    .op_i         (dec_i.op),
    .size_i       (dec_i.size),
    .unsign_i     (dec_i.unsign),
    .rs1_i        (dec_i.rs1),
    .rs2_i        (dec_i.rs2),
    .imm_i        (dec_i.imm),
    .load_data_i  (load_data_i),
    .req_o        (lsu_req),
    .load_res_o   (lsu_res),
    .misaligned_o (lsu_misaligned)
  );

  trap_ctrl u_trap_ctrl (
    .clk                 (clk),
    .reset_n             (reset_n),
    .valid_i             (dec_i.valid),
    .kill_i              (kill),
    .pc_i                (dec_i.pc),
    .illegal_i           (dec_i.illegal),
    .ecall_i             (dec_i.ecall),
    .ebreak_i            (dec_i.ebreak),
    .mret_i              (dec_i.mret),
    .sret_i              (dec_i.sret),
    .target_misaligned_i (sel_bu & bu_misaligned),
    .ld_misaligned_i     (lsu_misaligned & ~lsu_req.store),
    .st_misaligned_i     (lsu_misaligned & lsu_req.store),
    .target_i            (bu_target),
    .adr_i               (lsu_req.adr),
    .mtvec_i             (mtvec_i),
    .mepc_i              (mepc_i),
    .trap_now_o          (trap_now),
    .trap_o              (trap_o),
    .xret_now_o          (xret_now),
    .redirect_pc_o       (trap_redirect_pc),
    .core_mode_o         (core_mode_o)
  );

  // Redirect opens the kill window for the next two instructions
  assign taken        = active & sel_bu & bu_taken;
  assign redirect_now = taken | trap_now | xret_now;

  flush_timer u_flush_timer (
    .clk     (clk),
    .reset_n (reset_n),
    .start_i (redirect_now),
    .kill_o  (kill)
  );

  // ------------------------------------------------------------
  // Result selection
  // ------------------------------------------------------------
  always_comb begin
    if (dec_i.csr_wbk) begin
      // rs2 holds the old CSR value
      rd_data = dec_i.rs2;
    end else begin
      case (dec_i.unit)
        UNIT_ALU, UNIT_SFT: rd_data = alu_res;
        UNIT_BU:            rd_data = bu_link;
        UNIT_LSU:           rd_data = lsu_res;
        default:            rd_data = '0;
      endcase
    end
  end

  assign csr_data       = dec_i.csrrw ? dec_i.rs1 : alu_res;
  assign fwd_rd_data_o  = rd_data;
  assign fwd_csr_data_o = csr_data;

  always_comb begin
    mem_req_o       = lsu_req;
    mem_req_o.valid = lsu_req.valid & active & ~trap_now;
  end

  // ------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wbk_q      <= '0;
      csr_wbk_q  <= '0;
      redirect_q <= '0;
    end else begin
      wbk_q      <= '{valid: active & dec_i.rd_v & ~trap_now, adr: dec_i.rd_adr,
                      data: rd_data};
      csr_wbk_q  <= '{valid: active & dec_i.csr_wbk & ~trap_now, adr: dec_i.csr_adr,
                      data: csr_data};
      redirect_q <= '{valid: redirect_now,
                      pc: (trap_now | xret_now) ? trap_redirect_pc : bu_target};
    end
  end

  assign wbk_o      = wbk_q;
  assign csr_wbk_o  = csr_wbk_q;
  assign redirect_o = redirect_q;

endmodule

`default_nettype wire

/* rtl/exe_defs.svh */
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// ------------------------------------------------------------
// Execute stage dimensions
// ------------------------------------------------------------

// Data path width
`define EXE_XLEN 32

// Register address width
`define EXE_NB_REGS 5

// Instructions cancelled after every redirect
`define EXE_KILL_CYCLES 2

`endif

/* rtl/exe_pkg.sv */
`default_nettype none
`include "exe_defs.svh"

package exe_pkg;

  // One-hot unit select
  typedef enum logic [4:0] {
    UNIT_ALU  = 5'b00001,
    UNIT_SFT  = 5'b00010,
    UNIT_BU   = 5'b00100,
    UNIT_LSU  = 5'b01000,
    UNIT_NONE = 5'b10000
  } unit_e;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_SLT  = 4'd2,
    OP_SLTU = 4'd3,
    OP_XOR  = 4'd4,
    OP_OR   = 4'd5,
    OP_AND  = 4'd6,
    OP_SLL  = 4'd7,
    OP_SRL  = 4'd8,
    OP_SRA  = 4'd9,
    OP_BEQ  = 4'd10,
    OP_BNE  = 4'd11,
    OP_BLT  = 4'd12,
    OP_BGE  = 4'd13,
    OP_JAL  = 4'd14,
    OP_JALR = 4'd15
  } op_e;

  // LSU codes reuse ALU encodings, decoded per unit
  localparam op_e OP_LD = OP_ADD;
  localparam op_e OP_ST = OP_SUB;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  typedef enum logic [1:0] {
    MODE_U = 2'b00,
    MODE_S = 2'b01,
    MODE_M = 2'b11
  } mode_e;

  // ------------------------------------------------------------
  // Records crossing module boundaries
  // ------------------------------------------------------------

  typedef struct packed {
    logic                      valid;
    logic [`EXE_XLEN-1:0]      pc;
    logic [`EXE_XLEN-1:0]      rs1;
    logic [`EXE_XLEN-1:0]      rs2;
    logic [`EXE_XLEN-1:0]      imm;
    logic                      use_imm;
    logic                      unsign;
    size_e                     size;
    unit_e                     unit;
    op_e                       op;
    logic                      rd_v;
    logic [`EXE_NB_REGS-1:0]   rd_adr;
    logic                      csr_wbk;
    logic [11:0]               csr_adr;
    logic                      csrrw;
    logic                      illegal;
    logic                      ecall;
    logic                      ebreak;
    logic                      mret;
    logic                      sret;
  } dec_exe_t;

  typedef struct packed {
    logic                 valid;
    logic                 store;
    logic [`EXE_XLEN-1:0] adr;
    logic [`EXE_XLEN-1:0] wdata;
    size_e                size;
  } mem_req_t;

  typedef struct packed {
    logic                    valid;
    logic [`EXE_NB_REGS-1:0] adr;
    logic [`EXE_XLEN-1:0]    data;
  } wbk_t;

  typedef struct packed {
    logic                 valid;
    logic [11:0]          adr;
    logic [`EXE_XLEN-1:0] data;
  } csr_wbk_t;

  typedef struct packed {
    logic                 valid;
    logic [`EXE_XLEN-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic                 valid;
    logic [`EXE_XLEN-1:0] cause;
    logic [`EXE_XLEN-1:0] tval;
    logic [`EXE_XLEN-1:0] epc;
  } trap_t;

endpackage

`default_nettype wire

/* rtl/flush_timer.sv */
`default_nettype none
`include "exe_defs.svh"

module flush_timer (
  input  logic clk,
  input  logic reset_n,
  input  logic start_i,
  output logic kill_o
);

  localparam int CNT_W = $clog2(`EXE_KILL_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;

  // Reload on redirect, then count down to zero
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(`EXE_KILL_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign kill_o = cnt_q != '0;

endmodule

`default_nettype wire

/* rtl/lsu.sv */
`default_nettype none
`include "exe_defs.svh"

module lsu import exe_pkg::*; (
  input  logic                 en_i,
  input  op_e                  op_i,
  input  size_e                size_i,
  input  logic                 unsign_i,
  input  logic [`EXE_XLEN-1:0] rs1_i,
  input  logic [`EXE_XLEN-1:0] rs2_i,
  input  logic [`EXE_XLEN-1:0] imm_i,
  input  logic [`EXE_XLEN-1:0] load_data_i,
  output mem_req_t             req_o,
  output logic [`EXE_XLEN-1:0] load_res_o,
  output logic                 misaligned_o
);

  logic [`EXE_XLEN-1:0] adr;
  logic [7:0]           ld_byte;
  logic [15:0]          ld_half;

  assign adr = rs1_i + imm_i;

  assign misaligned_o = en_i & (((size_i == SIZE_HALF) & adr[0])
                      | ((size_i == SIZE_WORD) & (|adr[1:0])));

  // Store data goes out unshifted
  assign req_o = '{valid: en_i, store: (op_i == OP_ST), adr: adr, wdata: rs2_i, size: size_i};

  // Lane select by low address bits
  assign ld_byte = load_data_i[8*adr[1:0] +: 8];
  assign ld_half = load_data_i[16*adr[1] +: 16];

  always_comb begin
    case (size_i)
      SIZE_BYTE: load_res_o = {{(`EXE_XLEN-8){~unsign_i & ld_byte[7]}}, ld_byte};
      SIZE_HALF: load_res_o = {{(`EXE_XLEN-16){~unsign_i & ld_half[15]}}, ld_half};
      default:   load_res_o = load_data_i;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/trap_ctrl.sv */
`default_nettype none
`include "exe_defs.svh"

module trap_ctrl import exe_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 valid_i,
  input  logic                 kill_i,
  input  logic [`EXE_XLEN-1:0] pc_i,
  input  logic                 illegal_i,
  input  logic                 ecall_i,
  input  logic                 ebreak_i,
  input  logic                 mret_i,
  input  logic                 sret_i,
  input  logic                 target_misaligned_i,
  input  logic                 ld_misaligned_i,
  input  logic                 st_misaligned_i,
  input  logic [`EXE_XLEN-1:0] target_i,
  input  logic [`EXE_XLEN-1:0] adr_i,
  input  logic [`EXE_XLEN-1:0] mtvec_i,
  input  logic [`EXE_XLEN-1:0] mepc_i,
  output logic                 trap_now_o,
  output trap_t                trap_o,
  output logic                 xret_now_o,
  output logic [`EXE_XLEN-1:0] redirect_pc_o,
  output mode_e                core_mode_o
);

  logic                 active;
  logic                 exc;
  logic [`EXE_XLEN-1:0] cause;
  logic [`EXE_XLEN-1:0] tval;
  trap_t                trap_q;
  mode_e                mode_q;

  assign active = valid_i & ~kill_i;

  // ------------------------------------------------------------
  // Exception priority, highest first
  // ------------------------------------------------------------
  always_comb begin
    exc   = 1'b1;
    cause = '0;
    tval  = '0;
    if (target_misaligned_i) begin
      cause = `EXE_XLEN'(0);
      tval  = target_i;
    end else if (illegal_i) begin
      cause = `EXE_XLEN'(2);
    end else if (ebreak_i) begin
      cause = `EXE_XLEN'(3);
    end else if (ld_misaligned_i) begin
      cause = `EXE_XLEN'(4);
      tval  = adr_i;
    end else if (st_misaligned_i) begin
      cause = `EXE_XLEN'(6);
      tval  = adr_i;
    end else if (ecall_i) begin
      cause = `EXE_XLEN'(11);
    end else begin
      exc = 1'b0;
    end
  end

  assign trap_now_o = active & exc;
  // An excepting mret or sret traps instead of returning
  assign xret_now_o = active & ~exc & (mret_i | sret_i);

  // Both returns use mepc
  assign redirect_pc_o = exc ? mtvec_i : mepc_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      trap_q <= '0;
      mode_q <= MODE_M;
    end else begin
      trap_q <= '{valid: trap_now_o, cause: cause, tval: tval, epc: pc_i};
      // Mode FSM
      if (trap_now_o) begin
        mode_q <= MODE_M;
      end else if (xret_now_o & mret_i) begin
        mode_q <= MODE_U;
      end else if (xret_now_o & sret_i) begin
        mode_q <= MODE_S;
      end
    end
  end

  assign trap_o      = trap_q;
  assign core_mode_o = mode_q;

endmodule

`default_nettype wire
